/* Bender.yml */
package:
  name: cu_control

sources:
  - files:
      - rtl/cu_pkg.sv
      - rtl/cu_if.sv
      - rtl/cmd_fifo.sv
      - rtl/vertex_decode.sv
      - rtl/edge_execute.sv
      - rtl/result_writer.sv
      - rtl/mem_port_arbiter.sv
      - rtl/cu_control.sv
  - target: test
    files:
      - verif/cu_mem_model.sv
      - verif/cu_control_tb.sv

/* filelist.f */
rtl/cu_pkg.sv
rtl/cu_if.sv
rtl/cmd_fifo.sv
rtl/vertex_decode.sv
rtl/edge_execute.sv
rtl/result_writer.sv
rtl/mem_port_arbiter.sv
rtl/cu_control.sv
verif/cu_mem_model.sv
verif/cu_control_tb.sv

/* rtl/cmd_fifo.sv */
`timescale 1ns/10ps

module cmd_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);
	// show-ahead, head entry always visible
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

/* rtl/cu_control.sv */
`timescale 1ns/10ps

module cu_control #(
	parameter int RD_CREDITS = 4,
	parameter int WR_CREDITS = 2,
	parameter int VJOB_DEPTH = 4
) (
	input  logic            clock,
	input  logic            rstn,
	input  logic            job_start,
	input  cu_pkg::vid_t    num_vertices,
	input  cu_pkg::ecount_t num_edges,
	input  cu_pkg::addr_t   vertex_base,
	input  cu_pkg::addr_t   edge_base,
	input  cu_pkg::addr_t   result_base,
	input  logic            rd_credit,
	input  logic            rd_rsp_valid,
	input  cu_pkg::tag_t    rd_rsp_tag,
	input  cu_pkg::word_t   rd_rsp_data,
	input  logic            wr_credit,
	output logic            rd_req_valid,
	output cu_pkg::addr_t   rd_req_addr,
	output cu_pkg::tag_t    rd_req_tag,
	output logic            wr_valid,
	output cu_pkg::addr_t   wr_addr,
	output cu_pkg::word_t   wr_data,
	output logic            busy,
	output logic            done,
	output cu_pkg::vid_t    filtered_count,
	output cu_pkg::vid_t    written_count,
	output cu_pkg::ecount_t edge_count
);

	cu_pkg::vid_t    job_num_vertices;
	cu_pkg::ecount_t job_num_edges;
	cu_pkg::addr_t   job_vertex_base;
	cu_pkg::addr_t   job_edge_base;
	cu_pkg::addr_t   job_result_base;

	logic            vjob_push;
	logic            vjob_pop;
	logic            vjob_full;
	logic            vjob_empty;
	cu_pkg::vjob_t   vjob_in;
	cu_pkg::vjob_t   vjob_out;

	logic            vtx_rsp_valid;
	logic            edge_rsp_valid;
	cu_pkg::tag_t    rsp_tag;
	cu_pkg::word_t   rsp_data;

	rd_cmd_if vtx_cmd ();
	rd_cmd_if edge_cmd ();
	result_if res_bus ();

	//////////////////////////////////////////////////
	// job registers
	//////////////////////////////////////////////////

	// zero vertex count keeps decode quiet until the first job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_num_vertices <= '0;
			job_num_edges    <= '0;
			job_vertex_base  <= '0;
			job_edge_base    <= '0;
			job_result_base  <= '0;
		end else if (job_start) begin
			job_num_vertices <= num_vertices;
			job_num_edges    <= num_edges;
			job_vertex_base  <= vertex_base;
			job_edge_base    <= edge_base;
			job_result_base  <= result_base;
		end
	end

	//////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////

	vertex_decode #(
		.VJOB_DEPTH(VJOB_DEPTH)
	) vertex_decode_inst (
		.clock         (clock),
		.rstn          (rstn),
		.job_start     (job_start),
		.num_vertices  (job_num_vertices),
		.vertex_base   (job_vertex_base),
		.rsp_valid     (vtx_rsp_valid),
		.rsp_tag       (rsp_tag),
		.rsp_data      (rsp_data),
		.vjob_full     (vjob_full),
		.vjob_pop      (vjob_pop),
		.vjob_push     (vjob_push),
		.vjob_data     (vjob_in),
		.filtered_count(filtered_count),
		.cmd           (vtx_cmd)
	);

	// vertex job queue between decode and execute
	cmd_fifo #(
		.WIDTH($bits(cu_pkg::vjob_t)),
		.DEPTH(VJOB_DEPTH)
	) vjob_fifo_inst (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vjob_push),
		.data_in (vjob_in),
		.pop     (vjob_pop),
		.data_out(vjob_out),
		.full    (vjob_full),
		.empty   (vjob_empty)
	);

	edge_execute edge_execute_inst (
		.clock     (clock),
		.rstn      (rstn),
		.edge_base (job_edge_base),
		.vjob_empty(vjob_empty),
		.vjob_data (vjob_out),
		.rsp_valid (edge_rsp_valid),
		.rsp_tag   (rsp_tag),
		.rsp_data  (rsp_data),
		.vjob_pop  (vjob_pop),
		.cmd       (edge_cmd),
		.res       (res_bus)
	);

	result_writer #(
		.WR_CREDITS(WR_CREDITS)
	) result_writer_inst (
		.clock         (clock),
		.rstn          (rstn),
		.job_start     (job_start),
		.num_vertices  (job_num_vertices),
		.num_edges     (job_num_edges),
		.result_base   (job_result_base),
		.filtered_count(filtered_count),
		.wr_credit     (wr_credit),
		.wr_valid      (wr_valid),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.written_count (written_count),
		.edge_count    (edge_count),
		.done          (done),
		.busy          (busy),
		.res           (res_bus)
	);

	mem_port_arbiter #(
		.RD_CREDITS(RD_CREDITS)
	) mem_port_arbiter_inst (
		.clock         (clock),
		.rstn          (rstn),
		.rd_credit     (rd_credit),
		.rd_rsp_valid  (rd_rsp_valid),
		.rd_rsp_tag    (rd_rsp_tag),
		.rd_rsp_data   (rd_rsp_data),
		.rd_req_valid  (rd_req_valid),
		.rd_req_addr   (rd_req_addr),
		.rd_req_tag    (rd_req_tag),
		.vtx_rsp_valid (vtx_rsp_valid),
		.edge_rsp_valid(edge_rsp_valid),
		.rsp_tag       (rsp_tag),
		.rsp_data      (rsp_data),
		.cmd_vertex    (vtx_cmd),
		.cmd_edge      (edge_cmd)
	);

endmodule

/* rtl/cu_if.sv */
`timescale 1ns/10ps

// read command from one stage towards the memory port
interface rd_cmd_if;
	logic          valid;
	logic          ready;
	cu_pkg::addr_t addr;
	cu_pkg::tag_t  tag;

	modport requester (
		output valid,
		output addr,
		output tag,
		input  ready
	);

	modport arbiter (
		input  valid,
		input  addr,
		input  tag,
		output ready
	);
endinterface

// finished vertex from execute to the writer
interface result_if;
	logic            valid;
	logic            ready;
	cu_pkg::vid_t    vid;
	cu_pkg::sum_t    sum;
	cu_pkg::ecount_t ecount;

	modport source (
		output valid,
		output vid,
		output sum,
		output ecount,
		input  ready
	);

	modport sink (
		input  valid,
		input  vid,
		input  sum,
		input  ecount,
		output ready
	);
endinterface

/* rtl/cu_pkg.sv */
package cu_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [63:0] word_t;
	typedef logic [14:0] vid_t;
	typedef logic [31:0] ecount_t;
	typedef logic [15:0] tag_t;
	typedef logic [63:0] sum_t;

	// top bit of every read tag
	typedef enum logic {
		UNIT_VERTEX = 1'b0,
		UNIT_EDGE   = 1'b1
	} unit_e;

	localparam int unsigned WORD_BYTES   = 8;
	localparam int          TAG_UNIT_BIT = 15;

	// vertex id, first edge index and degree, high to low
	typedef logic [$bits(vid_t)+2*$bits(ecount_t)-1:0] vjob_t;

	// vertex record holds first edge index above the degree
	function automatic ecount_t vrec_degree(word_t w);
		return w[31:0];
	endfunction

	function automatic ecount_t vrec_first(word_t w);
		return w[63:32];
	endfunction

	// edge record holds the neighbor id in its low bits
	function automatic vid_t erec_nbr(word_t w);
		return w[14:0];
	endfunction

	function automatic tag_t make_tag(unit_e src, vid_t vid);
		return {src, vid};
	endfunction

	function automatic unit_e tag_unit(tag_t t);
		return unit_e'(t[TAG_UNIT_BIT]);
	endfunction

	function automatic vid_t tag_vid(tag_t t);
		return t[14:0];
	endfunction

	function automatic vjob_t vjob_pack(vid_t vid, ecount_t first_idx, ecount_t degree);
		return {vid, first_idx, degree};
	endfunction

endpackage

/* rtl/edge_execute.sv */
`timescale 1ns/10ps

module edge_execute (
	input  logic          clock,
	input  logic          rstn,
	input  cu_pkg::addr_t edge_base,
	input  logic          vjob_empty,
	input  cu_pkg::vjob_t vjob_data,
	input  logic          rsp_valid,
	input  cu_pkg::tag_t  rsp_tag,
	input  cu_pkg::word_t rsp_data,
	output logic          vjob_pop,
	rd_cmd_if.requester   cmd,
	result_if.source      res
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_DRAIN,
		ST_REPORT
	} state_e;

	state_e          state;
	cu_pkg::vid_t    job_vid;
	cu_pkg::ecount_t job_first;
	cu_pkg::ecount_t job_degree;
	cu_pkg::ecount_t issued;
	cu_pkg::ecount_t received;
	cu_pkg::ecount_t edge_idx;
	cu_pkg::sum_t    sum;
	logic            issue;
	logic            rsp_hit;

	assign vjob_pop  = (state == ST_IDLE) && !vjob_empty;
	assign edge_idx  = job_first + issued;
	assign cmd.valid = (state == ST_ISSUE);
	assign cmd.addr  = edge_base + cu_pkg::addr_t'(edge_idx) * cu_pkg::WORD_BYTES;
	assign cmd.tag   = cu_pkg::make_tag(cu_pkg::UNIT_EDGE, job_vid);
	assign issue     = cmd.valid && cmd.ready;
	// edge tags carry the owning vertex id
	assign rsp_hit   = rsp_valid && (cu_pkg::tag_vid(rsp_tag) == job_vid);

	assign res.valid  = (state == ST_REPORT);
	assign res.vid    = job_vid;
	assign res.sum    = sum;
	assign res.ecount = job_degree;

	// job fields split from the queue head
	always_ff @(posedge clock) begin
		if (vjob_pop) begin
			{job_vid, job_first, job_degree} <= vjob_data;
		end
	end

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state  <= ST_IDLE;
			issued <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					issued <= '0;
					if (vjob_pop) begin
						state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (issue) begin
						issued <= issued + 1'b1;
						if (issued == job_degree - 1'b1) begin
							state <= ST_DRAIN;
						end
					end
				end
				// wait for the last reordered response
				ST_DRAIN: begin
					if (received == job_degree) begin
						state <= ST_REPORT;
					end
				end
				ST_REPORT: begin
					if (res.ready) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// responses may arrive in any order, so only count and add
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			received <= '0;
			sum      <= '0;
		end else if (state == ST_IDLE) begin
			received <= '0;
			sum      <= '0;
		end else if (rsp_hit) begin
			received <= received + 1'b1;
			sum      <= sum + cu_pkg::sum_t'(cu_pkg::erec_nbr(rsp_data));
		end
	end

endmodule

/* rtl/mem_port_arbiter.sv */
`timescale 1ns/10ps

module mem_port_arbiter #(
	parameter int RD_CREDITS = 4
) (
	input  logic          clock,
	input  logic          rstn,
	input  logic          rd_credit,
	input  logic          rd_rsp_valid,
	input  cu_pkg::tag_t  rd_rsp_tag,
	input  cu_pkg::word_t rd_rsp_data,
	output logic          rd_req_valid,
	output cu_pkg::addr_t rd_req_addr,
	output cu_pkg::tag_t  rd_req_tag,
	output logic          vtx_rsp_valid,
	output logic          edge_rsp_valid,
	output cu_pkg::tag_t  rsp_tag,
	output cu_pkg::word_t rsp_data,
	rd_cmd_if.arbiter     cmd_vertex,
	rd_cmd_if.arbiter     cmd_edge
);

	localparam int CR_W = $clog2(RD_CREDITS + 1);

	logic [CR_W-1:0] credits;
	logic            has_credit;
	logic            edge_first;
	logic            grant_vertex;
	logic            grant_edge;
	logic            fire;

	//////////////////////////////////////////////////
	// round robin grant
	//////////////////////////////////////////////////

	assign has_credit   = (credits != '0);
	// edge_first says who wins when both ask
	assign grant_vertex = has_credit && cmd_vertex.valid && !(cmd_edge.valid && edge_first);
	assign grant_edge   = has_credit && cmd_edge.valid && !grant_vertex;
	assign fire         = grant_vertex || grant_edge;

	assign cmd_vertex.ready = grant_vertex;
	assign cmd_edge.ready   = grant_edge;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits      <= CR_W'(RD_CREDITS);
			edge_first   <= 1'b0;
			rd_req_valid <= 1'b0;
		end else begin
			credits      <= credits - CR_W'(fire) + CR_W'(rd_credit);
			rd_req_valid <= fire;
			if (fire) begin
				edge_first <= grant_vertex;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			rd_req_addr <= grant_edge ? cmd_edge.addr : cmd_vertex.addr;
			rd_req_tag  <= grant_edge ? cmd_edge.tag : cmd_vertex.tag;
		end
	end

	//////////////////////////////////////////////////
	// response routing by tag unit
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vtx_rsp_valid  <= 1'b0;
			edge_rsp_valid <= 1'b0;
		end else begin
			vtx_rsp_valid  <= rd_rsp_valid
				&& (cu_pkg::tag_unit(rd_rsp_tag) == cu_pkg::UNIT_VERTEX);
			edge_rsp_valid <= rd_rsp_valid
				&& (cu_pkg::tag_unit(rd_rsp_tag) == cu_pkg::UNIT_EDGE);
		end
	end

	always_ff @(posedge clock) begin
		if (rd_rsp_valid) begin
			rsp_tag  <= rd_rsp_tag;
			rsp_data <= rd_rsp_data;
		end
	end

endmodule

/* rtl/result_writer.sv */
`timescale 1ns/10ps

module result_writer #(
	parameter int WR_CREDITS = 2
) (
	input  logic            clock,
	input  logic            rstn,
	input  logic            job_start,
	input  cu_pkg::vid_t    num_vertices,
	input  cu_pkg::ecount_t num_edges,
	input  cu_pkg::addr_t   result_base,
	input  cu_pkg::vid_t    filtered_count,
	input  logic            wr_credit,
	output logic            wr_valid,
	output cu_pkg::addr_t   wr_addr,
	output cu_pkg::word_t   wr_data,
	output cu_pkg::vid_t    written_count,
	output cu_pkg::ecount_t edge_count,
	output logic            done,
	output logic            busy,
	result_if.sink          res
);

	localparam int CR_W = $clog2(WR_CREDITS + 1);

	logic [CR_W-1:0] credits;
	logic            accept;
	logic            job_valid;
	logic            all_seen;

	assign res.ready = (credits != '0);
	assign accept    = res.valid && res.ready;

	// every vertex either filtered or written, every edge summed
	assign all_seen = ({1'b0, filtered_count} + {1'b0, written_count} == {1'b0, num_vertices})
		&& (edge_count == num_edges);
	assign done = job_valid && all_seen;
	assign busy = job_valid && !all_seen;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits  <= CR_W'(WR_CREDITS);
			wr_valid <= 1'b0;
		end else begin
			credits  <= credits - CR_W'(accept) + CR_W'(wr_credit);
			wr_valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			wr_addr <= result_base + cu_pkg::addr_t'(res.vid) * cu_pkg::WORD_BYTES;
			wr_data <= cu_pkg::word_t'(res.sum);
		end
	end

	//////////////////////////////////////////////////
	// completion counters
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid     <= 1'b0;
			written_count <= '0;
			edge_count    <= '0;
		end else if (job_start) begin
			job_valid     <= 1'b1;
			written_count <= '0;
			edge_count    <= '0;
		end else if (accept) begin
			written_count <= written_count + 1'b1;
			edge_count    <= edge_count + res.ecount;
		end
	end

endmodule

/* rtl/vertex_decode.sv */
`timescale 1ns/10ps

module vertex_decode #(
	parameter int VJOB_DEPTH = 4
) (
	input  logic          clock,
	input  logic          rstn,
	input  logic          job_start,
	input  cu_pkg::vid_t  num_vertices,
	input  cu_pkg::addr_t vertex_base,
	input  logic          rsp_valid,
	input  cu_pkg::tag_t  rsp_tag,
	input  cu_pkg::word_t rsp_data,
	input  logic          vjob_full,
	input  logic          vjob_pop,
	output logic          vjob_push,
	output cu_pkg::vjob_t vjob_data,
	output cu_pkg::vid_t  filtered_count,
	rd_cmd_if.requester   cmd
);

	localparam int RES_W = $clog2(VJOB_DEPTH + 1);

	cu_pkg::vid_t     next_vid;
	logic [RES_W-1:0] reserved;
	logic             room;
	logic             issue;
	logic             filtered;

	//////////////////////////////////////////////////
	// vertex read requests
	//////////////////////////////////////////////////

	// one queue slot held per read, from request until the job is popped
	assign room      = (reserved < RES_W'(VJOB_DEPTH)) && !vjob_full;
	assign cmd.valid = (next_vid < num_vertices) && room;
	assign cmd.addr  = vertex_base + cu_pkg::addr_t'(next_vid) * cu_pkg::WORD_BYTES;
	assign cmd.tag   = cu_pkg::make_tag(cu_pkg::UNIT_VERTEX, next_vid);
	assign issue     = cmd.valid && cmd.ready;

	//////////////////////////////////////////////////
	// response filter
	//////////////////////////////////////////////////

	assign filtered  = rsp_valid && (cu_pkg::vrec_degree(rsp_data) == '0);
	assign vjob_push = rsp_valid && !filtered;
	assign vjob_data = cu_pkg::vjob_pack(cu_pkg::tag_vid(rsp_tag),
		cu_pkg::vrec_first(rsp_data), cu_pkg::vrec_degree(rsp_data));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_vid       <= '0;
			filtered_count <= '0;
		end else if (job_start) begin
			next_vid       <= '0;
			filtered_count <= '0;
		end else begin
			if (issue) begin
				next_vid <= next_vid + 1'b1;
			end
			if (filtered) begin
				filtered_count <= filtered_count + 1'b1;
			end
		end
	end

	// filtered vertices free their slot at once, queued jobs on pop
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			reserved <= '0;
		end else begin
			reserved <= reserved + RES_W'(issue) - RES_W'(filtered) - RES_W'(vjob_pop);
		end
	end

endmodule

/* verif/cu_control_tb.sv */
`timescale 1ns/10ps

module cu_control_tb;

	localparam int RD_CREDITS = 4;
	localparam int WR_CREDITS = 2;
	localparam int VJOB_DEPTH = 4;
	localparam int MAX_DELAY  = 8;
	localparam int VBASE      = 32'h0000_0000;
	localparam int EBASE      = 32'h0000_0800;

	logic            clock;
	logic            rstn;
	logic            job_start;
	cu_pkg::vid_t    num_vertices;
	cu_pkg::ecount_t num_edges;
	cu_pkg::addr_t   vertex_base;
	cu_pkg::addr_t   edge_base;
	cu_pkg::addr_t   result_base;
	logic            rd_credit;
	logic            rd_rsp_valid;
	cu_pkg::tag_t    rd_rsp_tag;
	cu_pkg::word_t   rd_rsp_data;
	logic            wr_credit;
	logic            rd_req_valid;
	cu_pkg::addr_t   rd_req_addr;
	cu_pkg::tag_t    rd_req_tag;
	logic            wr_valid;
	cu_pkg::addr_t   wr_addr;
	cu_pkg::word_t   wr_data;
	logic            busy;
	logic            done;
	cu_pkg::vid_t    filtered_count;
	cu_pkg::vid_t    written_count;
	cu_pkg::ecount_t edge_count;
	logic            hold_rd_credits;
	logic            hold_wr_credits;

	// graph under test and its expected results
	int unsigned     g_deg[$];
	int unsigned     g_first[$];
	cu_pkg::vid_t    g_nbr[$];
	cu_pkg::sum_t    expect_sum[cu_pkg::addr_t];
	cu_pkg::vid_t    exp_filtered;
	cu_pkg::addr_t   rd_addrs[$];

	cu_control #(
		.RD_CREDITS(RD_CREDITS),
		.WR_CREDITS(WR_CREDITS),
		.VJOB_DEPTH(VJOB_DEPTH)
	) cu_control_inst (
		.clock(clock), .rstn(rstn), .job_start(job_start),
		.num_vertices(num_vertices), .num_edges(num_edges),
		.vertex_base(vertex_base), .edge_base(edge_base), .result_base(result_base),
		.rd_credit(rd_credit), .rd_rsp_valid(rd_rsp_valid), .rd_rsp_tag(rd_rsp_tag),
		.rd_rsp_data(rd_rsp_data), .wr_credit(wr_credit),
		.rd_req_valid(rd_req_valid), .rd_req_addr(rd_req_addr), .rd_req_tag(rd_req_tag),
		.wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
		.busy(busy), .done(done), .filtered_count(filtered_count),
		.written_count(written_count), .edge_count(edge_count)
	);

	cu_mem_model mem_model_inst (
		.clock(clock), .rstn(rstn),
		.hold_rd_credits(hold_rd_credits), .hold_wr_credits(hold_wr_credits),
		.rd_req_valid(rd_req_valid), .rd_req_addr(rd_req_addr), .rd_req_tag(rd_req_tag),
		.wr_valid(wr_valid), .rd_credit(rd_credit), .rd_rsp_valid(rd_rsp_valid),
		.rd_rsp_tag(rd_rsp_tag), .rd_rsp_data(rd_rsp_data), .wr_credit(wr_credit)
	);

	always #4 clock = ~clock;

	//////////////////////////////////////////////////
	// error reporting and compares
	//////////////////////////////////////////////////

	task automatic report_error(string msg);
		$display("ERR at %0t: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic abort_run(string msg);
		$display("run stopped at %0t: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_sum(cu_pkg::sum_t got, cu_pkg::sum_t exp, string what);
		if (got !== exp) report_error($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic check_addr(cu_pkg::addr_t got, cu_pkg::addr_t exp, string what);
		if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_vid(cu_pkg::vid_t got, cu_pkg::vid_t exp, string what);
		if (got !== exp) report_error($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic check_ecount(cu_pkg::ecount_t got, cu_pkg::ecount_t exp, string what);
		if (got !== exp) report_error($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic check_bit(logic got, logic exp, string what);
		if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	// writes may land in any order
	always @(negedge clock) begin
		if (rstn && wr_valid) begin
			if (!expect_sum.exists(wr_addr)) begin
				report_error($sformatf("write to unexpected address %h", wr_addr));
			end else begin
				check_sum(cu_pkg::sum_t'(wr_data), expect_sum[wr_addr], "result sum");
				expect_sum.delete(wr_addr);
			end
		end
	end

	// read addresses in issue order
	always @(negedge clock) begin
		if (rstn && rd_req_valid) begin
			rd_addrs.push_back(rd_req_addr);
		end
	end

	// credit limits seen from the memory side
	always @(posedge clock) begin
		if (rstn && mem_model_inst.reads_issued - mem_model_inst.rd_credits_back > RD_CREDITS)
			abort_run("more reads outstanding than read credits");
		if (rstn && mem_model_inst.writes_seen - mem_model_inst.wr_credits_back > WR_CREDITS)
			abort_run("more writes outstanding than write credits");
	end

	//////////////////////////////////////////////////
	// graph building
	//////////////////////////////////////////////////

	task automatic clear_graph();
		g_deg.delete();
		g_first.delete();
		g_nbr.delete();
	endtask

	task automatic add_vertex(int unsigned deg);
		g_first.push_back(g_nbr.size());
		g_deg.push_back(deg);
	endtask

	task automatic add_random_vertex(int unsigned deg);
		add_vertex(deg);
		for (int k = 0; k < deg; k++) begin
			g_nbr.push_back(cu_pkg::vid_t'(mem_model_inst.rand_bits(15)));
		end
	endtask

	// records into memory, expected sums into the map
	task automatic load_graph(cu_pkg::addr_t rbase);
		cu_pkg::sum_t s;
		expect_sum.delete();
		exp_filtered = '0;
		for (int v = 0; v < g_deg.size(); v++) begin
			mem_model_inst.mem[VBASE / 8 + v] = {g_first[v], g_deg[v]};
			s = '0;
			for (int k = 0; k < g_deg[v]; k++) begin
				s += g_nbr[g_first[v] + k];
			end
			if (g_deg[v] == 0) begin
				exp_filtered++;
			end else begin
				expect_sum[rbase + cu_pkg::addr_t'(v * 8)] = s;
			end
		end
		for (int e = 0; e < g_nbr.size(); e++) begin
			mem_model_inst.mem[EBASE / 8 + e] = {49'(e) ^ 49'h1_2345_6789, g_nbr[e]};
		end
	endtask

	//////////////////////////////////////////////////
	// job control
	//////////////////////////////////////////////////

	task automatic start_job(cu_pkg::addr_t rbase);
		job_start    = 1'b1;
		num_vertices = cu_pkg::vid_t'(g_deg.size());
		num_edges    = cu_pkg::ecount_t'(g_nbr.size());
		vertex_base  = VBASE;
		edge_base    = EBASE;
		result_base  = rbase;
		@(negedge clock);
		job_start = 1'b0;
		if (g_deg.size() > 0) begin
			check_bit(done, 1'b0, "done after job_start");
			check_bit(busy, 1'b1, "busy after job_start");
			check_vid(written_count, '0, "written_count after job_start");
			check_vid(filtered_count, '0, "filtered_count after job_start");
			check_ecount(edge_count, '0, "edge_count after job_start");
		end
	endtask

	task automatic finish_job();
		int limit;
		int cycles;
		limit  = (g_deg.size() + g_nbr.size()) * MAX_DELAY * 4 + 100;
		cycles = 0;
		while (done !== 1'b1) begin
			@(negedge clock);
			cycles++;
			if (cycles > limit) abort_run("timeout waiting for done");
		end
		@(negedge clock);
		if (expect_sum.size() != 0) abort_run("some results were never written");
		check_vid(filtered_count, exp_filtered, "filtered_count");
		check_vid(written_count, cu_pkg::vid_t'(g_deg.size()) - exp_filtered, "written_count");
		check_ecount(edge_count, cu_pkg::ecount_t'(g_nbr.size()), "edge_count");
		check_bit(busy, 1'b0, "busy at done");
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_single_vertex();
		clear_graph();
		add_vertex(3);
		g_nbr.push_back(15'd5);
		g_nbr.push_back(15'd9);
		g_nbr.push_back(15'd100);
		load_graph(32'h0000_4000);
		rd_addrs.delete();
		start_job(32'h0000_4000);
		finish_job();
		// one vertex read, then the edge reads in order
		check_ecount(cu_pkg::ecount_t'(rd_addrs.size()), 32'd4, "single vertex read count");
		check_addr(rd_addrs[0], VBASE, "vertex read address");
		for (int k = 0; k < 3; k++) begin
			check_addr(rd_addrs[1 + k], EBASE + k * 8, "edge read address");
		end
		check_vid(written_count, 15'd1, "single vertex written_count");
		check_ecount(edge_count, 32'd3, "single vertex edge_count");
	endtask

	task automatic test_filter_mix();
		int unsigned degs[6] = '{0, 2, 0, 1, 0, 3};
		clear_graph();
		foreach (degs[i]) add_random_vertex(degs[i]);
		load_graph(32'h0000_5000);
		start_job(32'h0000_5000);
		finish_job();
		check_vid(filtered_count + written_count, 15'd6, "filtered plus written");
	endtask

	task automatic test_credit_backpressure();
		int outstanding;
		int limit;
		int cycles;
		clear_graph();
		for (int v = 0; v < 8; v++) add_random_vertex(v % 3 + 1);
		load_graph(32'h0000_6000);
		hold_rd_credits = 1'b1;
		hold_wr_credits = 1'b1;
		start_job(32'h0000_6000);
		repeat (60) @(negedge clock);
		outstanding = mem_model_inst.reads_issued - mem_model_inst.rd_credits_back;
		check_ecount(cu_pkg::ecount_t'(outstanding), RD_CREDITS, "reads held at credit limit");
		// reads flow again, writes stay blocked
		hold_rd_credits = 1'b0;
		limit       = (g_deg.size() + g_nbr.size()) * MAX_DELAY * 4 + 100;
		cycles      = 0;
		outstanding = 0;
		while (outstanding < WR_CREDITS) begin
			@(negedge clock);
			cycles++;
			if (cycles > limit) abort_run("timeout waiting for writes under held credits");
			outstanding = mem_model_inst.writes_seen - mem_model_inst.wr_credits_back;
		end
		repeat (20) @(negedge clock);
		outstanding = mem_model_inst.writes_seen - mem_model_inst.wr_credits_back;
		check_ecount(cu_pkg::ecount_t'(outstanding), WR_CREDITS, "writes held at credit limit");
		hold_wr_credits = 1'b0;
		finish_job();
	endtask

	task automatic test_random_graph();
		clear_graph();
		for (int v = 0; v < 12; v++) add_random_vertex(mem_model_inst.rand_bits(2));
		load_graph(32'h0000_7000);
		start_job(32'h0000_7000);
		finish_job();
	endtask

	task automatic test_back_to_back();
		int reads_before;
		clear_graph();
		for (int v = 0; v < 5; v++) add_random_vertex(mem_model_inst.rand_bits(2) + 1);
		load_graph(32'h0000_5800);
		start_job(32'h0000_5800);
		finish_job();
		// empty job finishes on its own
		clear_graph();
		load_graph(32'h0000_5800);
		reads_before = mem_model_inst.reads_issued;
		start_job(32'h0000_5800);
		check_bit(done, 1'b1, "done one cycle after empty job");
		repeat (10) @(negedge clock);
		check_ecount(cu_pkg::ecount_t'(mem_model_inst.reads_issued - reads_before), '0,
			"reads for empty job");
		check_bit(done, 1'b1, "done holds after empty job");
	endtask

	initial begin
		clock           = 1'b0;
		rstn            = 1'b0;
		job_start       = 1'b0;
		num_vertices    = '0;
		num_edges       = '0;
		vertex_base     = '0;
		edge_base       = '0;
		result_base     = '0;
		hold_rd_credits = 1'b0;
		hold_wr_credits = 1'b0;
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_bit(done, 1'b0, "done after reset");
		check_bit(busy, 1'b0, "busy after reset");
		test_single_vertex();
		test_filter_mix();
		test_credit_backpressure();
		test_random_graph();
		test_back_to_back();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* verif/cu_mem_model.sv */
`timescale 1ns/10ps

module cu_mem_model #(
	parameter int MEM_WORDS = 1024
) (
	input  logic          clock,
	input  logic          rstn,
	input  logic          hold_rd_credits,
	input  logic          hold_wr_credits,
	input  logic          rd_req_valid,
	input  cu_pkg::addr_t rd_req_addr,
	input  cu_pkg::tag_t  rd_req_tag,
	input  logic          wr_valid,
	output logic          rd_credit,
	output logic          rd_rsp_valid,
	output cu_pkg::tag_t  rd_rsp_tag,
	output cu_pkg::word_t rd_rsp_data,
	output logic          wr_credit
);

	cu_pkg::word_t mem [MEM_WORDS];
	cu_pkg::tag_t  p_tag[$];
	cu_pkg::word_t p_data[$];
	int            p_wait[$];
	int            rd_owed;
	int            wr_owed;
	int            reads_issued;
	int            rd_credits_back;
	int            writes_seen;
	int            wr_credits_back;
	logic [31:0]   lfsr = 32'hdbaf_1a6e;

	// fibonacci lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	// background pattern over the whole index
	initial begin
		rd_credit    = 1'b0;
		rd_rsp_valid = 1'b0;
		rd_rsp_tag   = '0;
		rd_rsp_data  = '0;
		wr_credit    = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
		end
	end

	always @(negedge clock) begin
		int pick;
		rd_rsp_valid = 1'b0;
		rd_credit    = 1'b0;
		wr_credit    = 1'b0;
		pick         = -1;
		if (!rstn) begin
			p_tag.delete();
			p_data.delete();
			p_wait.delete();
			rd_owed         = 0;
			wr_owed         = 0;
			reads_issued    = 0;
			rd_credits_back = 0;
			writes_seen     = 0;
			wr_credits_back = 0;
		end else begin
			if (rd_req_valid) begin
				p_tag.push_back(rd_req_tag);
				p_data.push_back(mem[(rd_req_addr / cu_pkg::WORD_BYTES) % MEM_WORDS]);
				p_wait.push_back(int'(rand_bits(3)));
				reads_issued++;
			end
			if (wr_valid) begin
				wr_owed++;
				writes_seen++;
			end
			// one answer per cycle, whichever is due first in the list
			for (int i = 0; i < p_wait.size(); i++) begin
				if (p_wait[i] == 0 && pick < 0) begin
					pick = i;
				end else if (p_wait[i] > 0) begin
					p_wait[i]--;
				end
			end
			if (pick >= 0) begin
				rd_rsp_valid = 1'b1;
				rd_rsp_tag   = p_tag[pick];
				rd_rsp_data  = p_data[pick];
				p_tag.delete(pick);
				p_data.delete(pick);
				p_wait.delete(pick);
				rd_owed++;
			end
			if (!hold_rd_credits && rd_owed > 0) begin
				rd_credit = 1'b1;
				rd_owed--;
				rd_credits_back++;
			end
			if (!hold_wr_credits && wr_owed > 0) begin
				wr_credit = 1'b1;
				wr_owed--;
				wr_credits_back++;
			end
		end
	end

endmodule
